// File: source/uart_rx_pkg.sv
`default_nettype none

package uart_rx_pkg;

    // frame and timing
    localparam int data_bits  = 8;
    localparam int oversample = 16;  // samples per bit
    localparam int baud_div   = 4;   // clocks per sample tick

    // buffering and flow control
    localparam int fifo_depth        = 8;
    localparam int almost_full_level = 6;
    localparam int credit_max        = 4;  // credits granted after reset

    typedef logic [7:0] data_t;
    typedef logic [3:0] fifo_count_t;  // 0 to fifo_depth
    typedef logic [2:0] credit_t;      // 0 to credit_max
    typedef logic [3:0] sample_cnt_t;  // position inside one bit
    typedef logic [2:0] bit_idx_t;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_t;

    // sampler to controller
    typedef struct packed {
        logic start_edge;
        logic bit_tick;   // middle of a bit
        logic bit_value;  // majority vote
    } bit_sample_t;

    typedef struct packed {
        logic frame_error;
        logic overrun;
    } rx_event_t;

endpackage

`default_nettype wire

// File: source/uart_rx_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_sampler
    import uart_rx_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rx,
    input  logic        framing,
    output bit_sample_t sample
);

    logic                        rx_meta;
    logic                        rx_sync;
    logic                        rx_prev;
    logic [$clog2(baud_div)-1:0] div_cnt;
    sample_cnt_t                 sample_cnt;
    logic [1:0]                  vote_hist;  // samples 7 and 8 when voting
    logic                        sample_tick;
    logic                        vote_now;
    logic                        majority;
    logic                        start_edge;
    logic                        bit_tick_q;
    logic                        bit_value_q;

    // two flop synchronizer, line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge  = !framing && rx_prev && !rx_sync;
    assign sample_tick = framing && (div_cnt == baud_div - 1);
    assign vote_now    = sample_tick && (sample_cnt == sample_cnt_t'(oversample / 2 + 1));

    // 2 of 3 on samples 7, 8 and 9
    assign majority = (vote_hist[1] & vote_hist[0]) |
                      (vote_hist[1] & rx_sync) |
                      (vote_hist[0] & rx_sync);

    // counters sit at zero until the frame starts, which aligns them to the edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt    <= '0;
            sample_cnt <= '0;
        end else if (!framing) begin
            div_cnt    <= '0;
            sample_cnt <= '0;
        end else begin
            div_cnt <= sample_tick ? '0 : div_cnt + 1'b1;
            if (sample_tick) begin
                if (sample_cnt == sample_cnt_t'(oversample - 1))
                    sample_cnt <= '0;
                else
                    sample_cnt <= sample_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_tick)
            vote_hist <= {vote_hist[0], rx_sync};
        if (vote_now)
            bit_value_q <= majority;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            bit_tick_q <= 1'b0;
        else
            bit_tick_q <= vote_now;  // one cycle pulse
    end

    always_comb begin
        sample.start_edge = start_edge;
        sample.bit_tick   = bit_tick_q;
        sample.bit_value  = bit_value_q;
    end

    // controller must still be framing when the vote arrives
    tick_in_frame_a: assert property (@(posedge clk) disable iff (!rst_n)
        sample.bit_tick |-> framing);

endmodule

`default_nettype wire

// File: source/uart_rx_controller.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_controller
    import uart_rx_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  bit_sample_t sample,
    input  logic        full,
    output logic        framing,
    output logic        wr_en,
    output data_t       wr_data,
    output rx_event_t   event_out
);

    rx_state_t state;
    bit_idx_t  bit_idx;
    data_t     shift_reg;

    assign framing = (state != st_idle);
    assign wr_data = shift_reg;  // stable from the last data bit until the next frame

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            bit_idx   <= '0;
            wr_en     <= 1'b0;
            event_out <= '0;
        end else begin
            // pulses by default
            wr_en     <= 1'b0;
            event_out <= '0;

            case (state)
                st_idle: begin
                    if (sample.start_edge)
                        state <= st_start;
                end

                st_start: begin
                    if (sample.bit_tick) begin
                        if (!sample.bit_value) begin
                            state   <= st_data;
                            bit_idx <= '0;
                        end else begin
                            state <= st_idle;  // glitch, false start
                        end
                    end
                end

                st_data: begin
                    if (sample.bit_tick) begin
                        if (bit_idx == bit_idx_t'(data_bits - 1))
                            state <= st_stop;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                end

                st_stop: begin
                    if (sample.bit_tick) begin
                        state                 <= st_idle;
                        wr_en                 <= sample.bit_value && !full;
                        event_out.frame_error <= !sample.bit_value;
                        event_out.overrun     <= sample.bit_value && full;
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (state == st_data && sample.bit_tick)
            shift_reg <= {sample.bit_value, shift_reg[data_bits-1:1]};
    end

    write_xor_event_a: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> (event_out == '0));

    // full may only fall between decision and write
    no_write_when_full_a: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !full);

endmodule

`default_nettype wire

// File: source/uart_rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fifo
    import uart_rx_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_en,
    input  data_t       wr_data,
    input  logic        rd_en,
    output data_t       rd_data,
    output logic        full,
    output logic        almost_full,
    output logic        empty,
    output fifo_count_t count
);

    localparam int ptr_w = $clog2(fifo_depth);

    data_t            mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             wr_ok;
    logic             rd_ok;

    assign full        = (count == fifo_count_t'(fifo_depth));
    assign almost_full = (count >= fifo_count_t'(almost_full_level));
    assign empty       = (count == '0);

    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_ok)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none, or both at once
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok)
            mem[wr_ptr] <= wr_data;
    end

    // read data valid the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_ok)
            rd_data <= mem[rd_ptr];
    end

    count_bound_a: assert property (@(posedge clk) disable iff (!rst_n)
        count <= fifo_count_t'(fifo_depth));

endmodule

`default_nettype wire

// File: source/uart_rx_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_datapath
    import uart_rx_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  bit_sample_t sample,
    output logic        framing,
    input  logic        credit_return,
    output logic        out_valid,
    output data_t       out_data,
    output logic        almost_full,
    output rx_event_t   event_out
);

    logic        wr_en;
    data_t       wr_data;
    logic        rd_en;
    logic        fifo_full;
    logic        fifo_empty;
    credit_t     credits;

    uart_rx_controller u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample    (sample),
        .full      (fifo_full),
        .framing   (framing),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .event_out (event_out)
    );

    uart_rx_fifo u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .rd_en       (rd_en),
        .rd_data     (out_data),  // registered in the fifo
        .full        (fifo_full),
        .almost_full (almost_full),
        .empty       (fifo_empty),
        .count       ()
    );

    // one credit per byte handed out
    assign rd_en = !fifo_empty && (credits != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= credit_t'(credit_max);
        end else begin
            case ({rd_en, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= rd_en;  // lines up with fifo read data
    end

    // consumer returned a credit it never had
    credit_overflow_a: assert property (@(posedge clk) disable iff (!rst_n)
        (credit_return && !rd_en) |-> (credits < credit_t'(credit_max)));

endmodule

`default_nettype wire

// File: source/uart_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_top
    import uart_rx_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      rx,             // async serial line
    input  logic      credit_return,
    output logic      out_valid,
    output data_t     out_data,
    output logic      almost_full,
    output rx_event_t event_out
);

    bit_sample_t sample;
    logic        framing;

    uart_rx_sampler u_sampler (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx      (rx),
        .framing (framing),
        .sample  (sample)
    );

    uart_rx_datapath u_datapath (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample        (sample),
        .framing       (framing),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .almost_full   (almost_full),
        .event_out     (event_out)
    );

endmodule

`default_nettype wire

// File: tests/uart_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_tb
    import uart_rx_pkg::*;
();

    localparam int bit_clocks = oversample * baud_div;  // 64 clocks per bit
    localparam int idle_gap   = 32;
    localparam int max_cycles = 60000;  // about 60 frames of 640 clocks plus margin
    localparam int wait_limit = 4 * bit_clocks;
    localparam int no_limit   = 1 << 30;

    typedef enum logic [1:0] {
        out_deliver,
        out_frame_error,
        out_overrun
    } outcome_t;

    typedef struct packed {
        outcome_t kind;
        data_t    data;
    } expect_t;

    logic      clk;
    logic      rst_n;
    logic      rx;
    logic      credit_return = 1'b0;
    logic      out_valid;
    data_t     out_data;
    logic      almost_full;
    rx_event_t event_out;

    data_t     exp_bytes[$];
    rx_event_t exp_events[$];
    string     test_name     = "reset";
    int        error_cnt     = 0;
    int        check_cnt     = 0;
    int        cycle_cnt     = 0;
    int        received_cnt  = 0;
    int        expected_cnt  = 0;  // bytes queued for delivery so far
    int        event_cnt     = 0;
    int        returned_cnt  = 0;
    int        return_limit  = no_limit;
    int        model_fifo    = 0;
    int        model_credits = credit_max;
    logic      holding       = 1'b0;  // consumer keeps its credits

    uart_rx_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx            (rx),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .almost_full   (almost_full),
        .event_out     (event_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("run timed out after %0d cycles in test %s", cycle_cnt, test_name);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // scoreboard compare of bytes and event pulses
    always @(posedge clk) begin
        data_t     exp_byte;
        rx_event_t exp_event;
        if (rst_n) begin
            if (out_valid) begin
                received_cnt <= received_cnt + 1;
                check_cnt++;
                if (exp_bytes.size() == 0) begin
                    error_cnt++;
                    $display("%s: byte %02h came out with none expected", test_name, out_data);
                end else begin
                    exp_byte = exp_bytes.pop_front();
                    if (out_data !== exp_byte) begin
                        error_cnt++;
                        $display("Fail %s: expected byte %02h, actual %02h",
                                 test_name, exp_byte, out_data);
                    end
                end
            end
            if (event_out !== '0) begin
                event_cnt <= event_cnt + 1;
                check_cnt++;
                if (exp_events.size() == 0) begin
                    error_cnt++;
                    $display("%s: event %b pulsed with none expected", test_name, event_out);
                end else begin
                    exp_event = exp_events.pop_front();
                    if (event_out !== exp_event) begin
                        error_cnt++;
                        $display("Fail %s: expected event %b, actual %b",
                                 test_name, exp_event, event_out);
                    end
                end
            end
        end
    end

    // consumer, one credit back per byte taken, up to return_limit
    always @(posedge clk) begin
        if (rst_n && received_cnt > returned_cnt && returned_cnt < return_limit) begin
            credit_return <= 1'b1;
            returned_cnt  <= returned_cnt + 1;
        end else begin
            credit_return <= 1'b0;
        end
    end

    // bad stop bit drops the byte, a full fifo drops a good one
    function automatic expect_t expected_outcome(input data_t b, input logic stop_bit,
                                                 input int occupancy);
        expect_t e;
        e.data = b;
        if (!stop_bit)
            e.kind = out_frame_error;
        else if (occupancy >= fifo_depth)
            e.kind = out_overrun;
        else
            e.kind = out_deliver;
        return e;
    endfunction

    task automatic drain_model();
        while (model_fifo > 0 && model_credits > 0) begin
            model_fifo--;
            if (holding)
                model_credits--;
        end
    endtask

    task automatic hold_line(input logic level, input int clocks);
        repeat (clocks) begin
            @(posedge clk);
            rx <= level;
        end
    endtask

    task automatic send_frame(input data_t b, input logic stop_bit);
        hold_line(1'b0, bit_clocks);  // start bit
        for (int i = 0; i < data_bits; i++)
            hold_line(b[i], bit_clocks);
        hold_line(stop_bit, bit_clocks);
        hold_line(1'b1, idle_gap);
    endtask

    task automatic run_frame(input data_t b, input logic stop_bit);
        expect_t   e;
        rx_event_t ev;
        logic      af_exp;
        e  = expected_outcome(b, stop_bit, model_fifo);
        ev = '0;
        case (e.kind)
            out_deliver: begin
                exp_bytes.push_back(e.data);
                expected_cnt++;
                model_fifo++;
            end
            out_frame_error: begin
                ev.frame_error = 1'b1;
                exp_events.push_back(ev);
            end
            default: begin
                ev.overrun = 1'b1;
                exp_events.push_back(ev);
            end
        endcase
        drain_model();
        send_frame(b, stop_bit);
        af_exp = (model_fifo >= almost_full_level);
        check_cnt++;
        if (almost_full !== af_exp) begin
            error_cnt++;
            $display("Fail %s: expected almost_full %0b, actual %0b",
                     test_name, af_exp, almost_full);
        end
    endtask

    task automatic wait_received(input int target);
        int waited;
        waited = 0;
        while (received_cnt < target && waited < wait_limit) begin
            @(posedge clk);
            waited++;
        end
        if (received_cnt < target) begin
            error_cnt++;
            $display("%s: only %0d of %0d bytes arrived in time", test_name, received_cnt, target);
        end
    endtask

    task automatic settle_credits();
        int waited;
        waited = 0;
        while ((received_cnt != expected_cnt || returned_cnt != received_cnt) &&
               waited < 4 * wait_limit) begin
            @(posedge clk);
            waited++;
        end
        if (received_cnt != expected_cnt || returned_cnt != received_cnt) begin
            error_cnt++;
            $display("%s: bytes or credits still outstanding", test_name);
        end
    endtask

    task automatic hold_credits();
        settle_credits();
        @(posedge clk);
        return_limit  <= returned_cnt;
        holding       = 1'b1;
        model_credits = credit_max;
    endtask

    task automatic release_credits();
        @(posedge clk);
        return_limit  <= no_limit;
        holding       = 1'b0;
        model_credits = credit_max;
        drain_model();
        settle_credits();
    endtask

    initial begin
        int base;
        int ev_base;
        void'($urandom(32'h124f130c));
        rst_n = 1'b0;
        rx    = 1'b1;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "stream";
        repeat (100) begin
            @(posedge clk);
            check_cnt++;
            if (out_valid !== 1'b0 || event_out !== '0) begin
                error_cnt++;
                $display("%s: output active while rx idles high", test_name);
            end
        end
        base = received_cnt;
        repeat (20) run_frame(data_t'($urandom), 1'b1);
        settle_credits();
        check_cnt++;
        if (received_cnt - base != 20) begin
            error_cnt++;
            $display("Fail %s: expected 20 bytes, actual %0d", test_name, received_cnt - base);
        end

        test_name = "frame_error";
        base = received_cnt;
        run_frame(data_t'($urandom), 1'b0);
        run_frame(data_t'($urandom), 1'b1);
        settle_credits();
        check_cnt++;
        if (received_cnt - base != 1) begin
            error_cnt++;
            $display("Fail %s: expected 1 byte, actual %0d", test_name, received_cnt - base);
        end

        test_name = "glitch";  // shorter than half a bit
        base    = received_cnt;
        ev_base = event_cnt;
        hold_line(1'b0, 20);
        hold_line(1'b1, 2 * bit_clocks);
        check_cnt++;
        if (received_cnt != base || event_cnt != ev_base) begin
            error_cnt++;
            $display("%s: short low pulse gave a byte or an event", test_name);
        end

        test_name = "backpressure";
        hold_credits();
        base = received_cnt;
        repeat (credit_max + almost_full_level) run_frame(data_t'($urandom), 1'b1);
        check_cnt++;
        if (received_cnt - base != credit_max) begin
            error_cnt++;
            $display("Fail %s: expected %0d bytes, actual %0d",
                     test_name, credit_max, received_cnt - base);
        end
        for (int i = 1; i <= almost_full_level; i++) begin
            @(posedge clk);
            return_limit <= return_limit + 1;  // one credit at a time
            model_credits++;
            drain_model();
            wait_received(base + credit_max + i);
        end
        release_credits();

        test_name = "overrun";
        hold_credits();
        base = received_cnt;
        repeat (credit_max + fifo_depth + 2) run_frame(data_t'($urandom), 1'b1);
        check_cnt++;
        if (received_cnt - base != credit_max) begin
            error_cnt++;
            $display("Fail %s: expected %0d bytes, actual %0d",
                     test_name, credit_max, received_cnt - base);
        end
        release_credits();
        check_cnt++;
        if (received_cnt - base != credit_max + fifo_depth) begin
            error_cnt++;
            $display("Fail %s: expected %0d bytes, actual %0d",
                     test_name, credit_max + fifo_depth, received_cnt - base);
        end

        repeat (bit_clocks) @(posedge clk);
        if (exp_bytes.size() != 0 || exp_events.size() != 0) begin
            error_cnt++;
            $display("%0d bytes and %0d events never appeared",
                     exp_bytes.size(), exp_events.size());
        end
        $display("checks %0d, errors %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
source/uart_rx_pkg.sv
source/uart_rx_sampler.sv
source/uart_rx_controller.sv
source/uart_rx_fifo.sv
source/uart_rx_datapath.sv
source/uart_rx_top.sv
tests/uart_rx_tb.sv

// File: Makefile
# Verilator build and run of the UART receiver testbench

VERILATOR ?= verilator
TOP       ?= uart_rx_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
